// File: rtl/pcs_rx_pkg.sv
// pcs receive decode definitions
package pcs_rx_pkg;

    // vector types
    typedef logic [65:0] coded_block_t;   // sync header, block type, payload
    typedef logic [63:0] cgmii_data_t;    // lane 0 in bits 63:56
    typedef logic [7:0]  cgmii_ctrl_t;    // bit 7 is lane 0
    typedef logic [3:0]  r_type_t;        // one-hot D S C T or zero for error
    typedef logic [6:0]  pcs_char_t;      // 7-bit control character

    typedef struct packed {
        cgmii_data_t data;
        cgmii_ctrl_t ctrl;
        r_type_t     r_type;
    } decoded_block_s;

    typedef enum logic [2:0] {
        RX_INIT,
        RX_C,
        RX_D,
        RX_T,
        RX_E
    } rx_state_e;

    // sync headers
    localparam logic [1:0] DATA_SH = 2'b01;
    localparam logic [1:0] CTRL_SH = 2'b10;

    // block type field
    localparam logic [7:0] BTYPE_CTRL  = 8'h1E;
    localparam logic [7:0] BTYPE_S     = 8'h78;
    localparam logic [7:0] BTYPE_ORDER = 8'h4B;
    localparam logic [7:0] BTYPE_T0    = 8'h87;
    localparam logic [7:0] BTYPE_T1    = 8'h99;
    localparam logic [7:0] BTYPE_T2    = 8'hAA;
    localparam logic [7:0] BTYPE_T3    = 8'hB4;
    localparam logic [7:0] BTYPE_T4    = 8'hCC;
    localparam logic [7:0] BTYPE_T5    = 8'hD2;
    localparam logic [7:0] BTYPE_T6    = 8'hE1;
    localparam logic [7:0] BTYPE_T7    = 8'hFF;

    // cgmii characters
    localparam logic [7:0] CGMII_IDLE      = 8'h07;
    localparam logic [7:0] CGMII_START     = 8'hFB;
    localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
    localparam logic [7:0] CGMII_ERROR     = 8'hFE;
    localparam logic [7:0] CGMII_Q         = 8'h9C;
    localparam logic [7:0] CGMII_FSIG      = 8'h5C;

    // pcs control characters and ordered set O codes
    localparam pcs_char_t  PCS_IDLE    = 7'h00;
    localparam pcs_char_t  PCS_ERROR   = 7'h1E;
    localparam logic [3:0] O_CODE_Q    = 4'h0;
    localparam logic [3:0] O_CODE_FSIG = 4'hF;

    // r_type codes
    localparam r_type_t RTYPE_E = 4'b0000;
    localparam r_type_t RTYPE_D = 4'b1000;
    localparam r_type_t RTYPE_S = 4'b0100;
    localparam r_type_t RTYPE_C = 4'b0010;
    localparam r_type_t RTYPE_T = 4'b0001;

    // control patterns
    localparam cgmii_ctrl_t CTRL_ALL   = 8'b1111_1111;
    localparam cgmii_ctrl_t CTRL_NONE  = 8'b0000_0000;
    localparam cgmii_ctrl_t CTRL_LANE0 = 8'b1000_0000;  // start and ordered sets

    // block lock
    localparam int LOCK_GOOD_COUNT = 64;
    localparam int LOCK_WINDOW     = 64;
    localparam int LOCK_BAD_LIMIT  = 16;

    typedef logic [$clog2(LOCK_WINDOW):0] lock_cnt_t;

    // local fault ordered set
    localparam cgmii_data_t LF_DATA = 64'h9C00_0001_0000_0000;
    localparam cgmii_ctrl_t LF_CTRL = 8'b1000_0000;

endpackage

// File: rtl/decoder_comparator.sv
// 64b/66b block decoder
`timescale 1ns/1ps

module decoder_comparator
(
    input  logic                       i_clock,
    input  logic                       i_rst_n,
    input  logic                       i_enable,
    input  pcs_rx_pkg::coded_block_t   i_rx_coded,
    output pcs_rx_pkg::decoded_block_s o_decoded,
    output logic                       o_valid
);

    import pcs_rx_pkg::*;

    logic [1:0]     sync_hdr;
    logic [7:0]     block_type;
    logic [55:0]    payload;
    logic [3:0]     o_code;       // ordered set code after D1..D3
    cgmii_data_t    term_data;    // payload bytes moved up to lane 0
    logic [7:0]     char_ok;      // bit 7 is char 0
    cgmii_data_t    char_map;     // chars mapped in lane positions
    logic           is_term;
    logic [2:0]     term_pos;     // lane holding the terminate
    logic [7:0]     trail_mask;   // lanes after the terminate
    decoded_block_s dec_n;

    // idle maps to idle, anything else comes out as error
    function automatic logic [7:0] pcs_to_cgmii(input pcs_char_t pcs);
        if (pcs == PCS_IDLE)
        begin
            return CGMII_IDLE;
        end
        return CGMII_ERROR;
    endfunction

    assign sync_hdr   = i_rx_coded[65:64];
    assign block_type = i_rx_coded[63:56];
    assign payload    = i_rx_coded[55:0];
    assign o_code     = payload[31:28];
    assign term_data  = {payload, 8'h00};

    // seven-bit chars sit at the bottom of the payload, char 7 in bits 6:0
    always_comb
    begin
        for (int k = 0; k < 8; k++)
        begin
            char_ok[7-k] = (payload[55-7*k -: 7] == PCS_IDLE) ||
                           (payload[55-7*k -: 7] == PCS_ERROR);
            char_map[63-8*k -: 8] = pcs_to_cgmii(payload[55-7*k -: 7]);
        end
    end

    always_comb
    begin
        is_term  = 1'b1;
        term_pos = 3'd0;
        case (block_type)
            BTYPE_T0: term_pos = 3'd0;
            BTYPE_T1: term_pos = 3'd1;
            BTYPE_T2: term_pos = 3'd2;
            BTYPE_T3: term_pos = 3'd3;
            BTYPE_T4: term_pos = 3'd4;
            BTYPE_T5: term_pos = 3'd5;
            BTYPE_T6: term_pos = 3'd6;
            BTYPE_T7: term_pos = 3'd7;
            default:  is_term  = 1'b0;
        endcase
    end

    assign trail_mask = 8'hFF >> (term_pos + 4'd1);  // empty for T7

    always_comb
    begin
        // illegal block unless one of the checks below passes
        dec_n.data   = {8{CGMII_ERROR}};
        dec_n.ctrl   = CTRL_ALL;
        dec_n.r_type = RTYPE_E;

        if (sync_hdr == DATA_SH)
        begin
            dec_n.data   = i_rx_coded[63:0];
            dec_n.ctrl   = CTRL_NONE;
            dec_n.r_type = RTYPE_D;
        end
        else if (sync_hdr == CTRL_SH)
        begin
            if (block_type == BTYPE_CTRL && payload == {8{PCS_IDLE}})
            begin
                dec_n.data   = {8{CGMII_IDLE}};
                dec_n.ctrl   = CTRL_ALL;
                dec_n.r_type = RTYPE_C;
            end
            else if (block_type == BTYPE_S)
            begin
                dec_n.data   = {CGMII_START, payload};
                dec_n.ctrl   = CTRL_LANE0;
                dec_n.r_type = RTYPE_S;
            end
            else if (block_type == BTYPE_ORDER && payload[27:0] == '0 &&
                     (o_code == O_CODE_Q || o_code == O_CODE_FSIG))
            begin
                // lanes 4..7 carry zero data
                dec_n.data   = {(o_code == O_CODE_Q) ? CGMII_Q : CGMII_FSIG,
                                payload[55:32], 32'h0};
                dec_n.ctrl   = CTRL_LANE0;
                dec_n.r_type = RTYPE_C;
            end
            else if (is_term && (char_ok & trail_mask) == trail_mask)
            begin
                for (int k = 0; k < 8; k++)
                begin
                    if (k < term_pos)
                        dec_n.data[63-8*k -: 8] = term_data[63-8*k -: 8];
                    else if (k == term_pos)
                        dec_n.data[63-8*k -: 8] = CGMII_TERMINATE;
                    else
                        dec_n.data[63-8*k -: 8] = char_map[63-8*k -: 8];
                end
                dec_n.ctrl   = CTRL_ALL >> term_pos;  // terminate lane and after
                dec_n.r_type = RTYPE_T;
            end
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_enable;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_enable)
            o_decoded <= dec_n;
    end

endmodule

// File: rtl/block_lock.sv
// sync header block lock
`timescale 1ns/1ps

module block_lock
(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  logic       i_enable,
    input  logic [1:0] i_sync_header,
    output logic       o_block_lock
);

    import pcs_rx_pkg::*;

    logic      hdr_ok;
    lock_cnt_t good_cnt;   // consecutive good headers while unlocked
    lock_cnt_t win_cnt;    // position in the loss window
    lock_cnt_t bad_cnt;    // bad headers seen in this window
    lock_cnt_t bad_next;

    assign hdr_ok   = (i_sync_header == DATA_SH) || (i_sync_header == CTRL_SH);
    assign bad_next = bad_cnt + lock_cnt_t'(!hdr_ok);

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_block_lock <= 1'b0;
            good_cnt     <= '0;
            win_cnt      <= '0;
            bad_cnt      <= '0;
        end
        else if (i_enable)
        begin
            if (!o_block_lock)
            begin
                win_cnt <= '0;
                bad_cnt <= '0;
                if (!hdr_ok)
                    good_cnt <= '0;  // start over
                else if (good_cnt == lock_cnt_t'(LOCK_GOOD_COUNT - 1))
                begin
                    o_block_lock <= 1'b1;
                    good_cnt     <= '0;
                end
                else
                    good_cnt <= good_cnt + 1'b1;
            end
            else if (bad_next == lock_cnt_t'(LOCK_BAD_LIMIT))
            begin
                o_block_lock <= 1'b0;  // too many bad headers
                win_cnt      <= '0;
                bad_cnt      <= '0;
            end
            else if (win_cnt == lock_cnt_t'(LOCK_WINDOW - 1))
            begin
                win_cnt <= '0;  // window done, lock kept
                bad_cnt <= '0;
            end
            else
            begin
                win_cnt <= win_cnt + 1'b1;
                bad_cnt <= bad_next;
            end
        end
    end

endmodule

// File: rtl/rx_decode_fsm.sv
// receive decode state machine
`timescale 1ns/1ps

module rx_decode_fsm
(
    input  logic                       i_clock,
    input  logic                       i_rst_n,
    input  pcs_rx_pkg::decoded_block_s i_decoded,
    input  logic                       i_valid,
    input  logic                       i_block_lock,
    output pcs_rx_pkg::cgmii_data_t    o_rx_data,
    output pcs_rx_pkg::cgmii_ctrl_t    o_rx_ctrl,
    output logic                       o_rx_valid
);

    import pcs_rx_pkg::*;

    rx_state_e   state;
    rx_state_e   state_n;
    cgmii_data_t data_n;
    cgmii_ctrl_t ctrl_n;

    // next state from the current block type
    always_comb
    begin
        state_n = RX_INIT;  // no lock
        if (i_block_lock)
        begin
            case (state)
                RX_INIT, RX_C, RX_T:
                begin
                    case (i_decoded.r_type)
                        RTYPE_C: state_n = RX_C;
                        RTYPE_S: state_n = RX_D;
                        default: state_n = RX_E;
                    endcase
                end
                RX_D:
                begin
                    case (i_decoded.r_type)
                        RTYPE_D: state_n = RX_D;
                        RTYPE_T: state_n = RX_T;
                        default: state_n = RX_E;
                    endcase
                end
                default:
                begin
                    // leave E on any legal block except a start
                    case (i_decoded.r_type)
                        RTYPE_C: state_n = RX_C;
                        RTYPE_D: state_n = RX_D;
                        RTYPE_T: state_n = RX_T;
                        default: state_n = RX_E;
                    endcase
                end
            endcase
        end
    end

    always_comb
    begin
        if (!i_block_lock)
        begin
            data_n = LF_DATA;
            ctrl_n = LF_CTRL;
        end
        else if (state_n == RX_E)
        begin
            data_n = {8{CGMII_ERROR}};  // replace the offending block
            ctrl_n = CTRL_ALL;
        end
        else
        begin
            data_n = i_decoded.data;
            ctrl_n = i_decoded.ctrl;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state      <= RX_INIT;
            o_rx_data  <= LF_DATA;
            o_rx_ctrl  <= LF_CTRL;
            o_rx_valid <= 1'b0;
        end
        else
        begin
            o_rx_valid <= i_valid;
            if (i_valid)
            begin
                state     <= state_n;
                o_rx_data <= data_n;
                o_rx_ctrl <= ctrl_n;
            end
        end
    end

endmodule

// File: rtl/pcs_rx_decode.sv
// pcs receive decode top
`timescale 1ns/1ps

module pcs_rx_decode
(
    input  logic                     i_clock,
    input  logic                     i_rst_n,
    input  logic                     i_enable,
    input  pcs_rx_pkg::coded_block_t i_rx_coded,
    output pcs_rx_pkg::cgmii_data_t  o_rx_data,
    output pcs_rx_pkg::cgmii_ctrl_t  o_rx_ctrl,
    output logic                     o_rx_valid,
    output logic                     o_block_lock
);

    import pcs_rx_pkg::*;

    decoded_block_s decoded;
    logic           decoded_valid;
    logic [1:0]     sync_header;

    assign sync_header = i_rx_coded[65:64];

    decoder_comparator u_decoder (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_enable   (i_enable),
        .i_rx_coded (i_rx_coded),
        .o_decoded  (decoded),
        .o_valid    (decoded_valid)
    );

    block_lock u_block_lock (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_sync_header (sync_header),
        .o_block_lock  (o_block_lock)  // also sampled by the fsm
    );

    rx_decode_fsm u_fsm (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_decoded    (decoded),
        .i_valid      (decoded_valid),
        .i_block_lock (o_block_lock),
        .o_rx_data    (o_rx_data),
        .o_rx_ctrl    (o_rx_ctrl),
        .o_rx_valid   (o_rx_valid)
    );

endmodule

// File: tb/tb_pcs_rx_decode.sv
// pcs receive decode testbench
`timescale 1ns/1ps

module tb_pcs_rx_decode;

    import pcs_rx_pkg::*;

    localparam int RESET_CYCLES = 10;

    typedef struct packed {
        coded_block_t coded;
        logic         enable;
        cgmii_data_t  exp_data;
        cgmii_ctrl_t  exp_ctrl;
        logic         exp_lock;
    } stim_entry_s;

    logic         i_clock;
    logic         i_rst_n;
    logic         i_enable;
    coded_block_t i_rx_coded;
    cgmii_data_t  o_rx_data;
    cgmii_ctrl_t  o_rx_ctrl;
    logic         o_rx_valid;
    logic         o_block_lock;

    stim_entry_s stim_q[$];
    int          cycle_count = 0;
    int          cycle_limit = 0;

    // reference model, only used while the table is built
    int          model_good;
    int          model_win;
    int          model_bad;
    logic        model_lock;
    rx_state_e   model_state;

    pcs_rx_decode dut (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_rx_coded   (i_rx_coded),
        .o_rx_data    (o_rx_data),
        .o_rx_ctrl    (o_rx_ctrl),
        .o_rx_valid   (o_rx_valid),
        .o_block_lock (o_block_lock)
    );

    initial
    begin
        i_clock = 1'b0;
        forever
            #50 i_clock = ~i_clock;
    end

    always @(posedge i_clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("FAIL: see errors above");
            $fatal(1, "run stopped by the cycle counter");
        end
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    function automatic logic [63:0] rand64();
        return {32'($urandom), 32'($urandom)};
    endfunction

    // lock model for one received header
    task automatic step_lock(input logic [1:0] hdr);
        logic ok;
        ok = (hdr == DATA_SH) || (hdr == CTRL_SH);
        if (!model_lock)
        begin
            model_good = ok ? model_good + 1 : 0;
            model_lock = (model_good == LOCK_GOOD_COUNT);
            model_win  = 0;
            model_bad  = 0;
            if (model_lock)
                model_good = 0;
        end
        else
        begin
            model_win = model_win + 1;
            model_bad = model_bad + (ok ? 0 : 1);
            if (model_bad == LOCK_BAD_LIMIT)
                model_lock = 1'b0;  // lost within this window
            if (model_bad == LOCK_BAD_LIMIT || model_win == LOCK_WINDOW)
            begin
                model_win = 0;
                model_bad = 0;
            end
        end
    endtask

    // one enabled block with its decoded form, run through lock and state model
    task automatic add_block(input coded_block_t coded, input cgmii_data_t dec_data,
                             input cgmii_ctrl_t dec_ctrl, input r_type_t rtype);
        stim_entry_s e;
        logic        legal;
        step_lock(coded[65:64]);
        e.coded    = coded;
        e.enable   = 1'b1;
        e.exp_lock = model_lock;
        if (!model_lock)
        begin
            model_state = RX_INIT;
            e.exp_data  = LF_DATA;
            e.exp_ctrl  = LF_CTRL;
        end
        else
        begin
            if (model_state == RX_D)
                legal = (rtype == RTYPE_D) || (rtype == RTYPE_T);
            else if (model_state == RX_E)
                legal = (rtype == RTYPE_C) || (rtype == RTYPE_D) || (rtype == RTYPE_T);
            else
                legal = (rtype == RTYPE_C) || (rtype == RTYPE_S);
            if (!legal)
                model_state = RX_E;
            else if (rtype == RTYPE_C)
                model_state = RX_C;
            else if (rtype == RTYPE_T)
                model_state = RX_T;
            else
                model_state = RX_D;  // start or data
            e.exp_data = legal ? dec_data : {8{CGMII_ERROR}};
            e.exp_ctrl = legal ? dec_ctrl : CTRL_ALL;
        end
        stim_q.push_back(e);
    endtask

    task automatic add_gap();
        stim_entry_s e;
        e = '0;
        e.coded    = {2'b00, rand64()};  // ignored while disabled
        e.exp_lock = model_lock;
        stim_q.push_back(e);
    endtask

    task automatic add_idle();
        add_block({CTRL_SH, BTYPE_CTRL, {8{PCS_IDLE}}}, {8{CGMII_IDLE}}, CTRL_ALL, RTYPE_C);
    endtask

    task automatic add_data();
        logic [63:0] d;
        d = rand64();
        add_block({DATA_SH, d}, d, CTRL_NONE, RTYPE_D);
    endtask

    task automatic add_start();
        logic [63:0] d;
        d = rand64();
        add_block({CTRL_SH, BTYPE_S, d[55:0]}, {CGMII_START, d[55:0]}, CTRL_LANE0, RTYPE_S);
    endtask

    task automatic add_ordered(input logic is_q);
        logic [63:0] d;
        d = rand64();
        add_block({CTRL_SH, BTYPE_ORDER, d[23:0], is_q ? O_CODE_Q : O_CODE_FSIG, 28'h0},
                  {is_q ? CGMII_Q : CGMII_FSIG, d[23:0], 32'h0}, CTRL_LANE0, RTYPE_C);
    endtask

    task automatic add_bad(input logic [1:0] hdr, input logic [7:0] btype);
        logic [63:0] d;
        d = rand64();
        add_block({hdr, btype, d[55:0]}, {8{CGMII_ERROR}}, CTRL_ALL, RTYPE_E);
    endtask

    // terminate in lane n, data bytes before it, trail chars after it
    task automatic add_term(input int n, input pcs_char_t trail);
        logic [55:0] p;
        logic [7:0]  b;
        cgmii_data_t data;
        cgmii_ctrl_t ctrl;
        logic [7:0]  btype;
        p     = '0;
        btype = (n == 0) ? BTYPE_T0 : (n == 1) ? BTYPE_T1 : (n == 2) ? BTYPE_T2 :
                (n == 3) ? BTYPE_T3 : (n == 4) ? BTYPE_T4 : (n == 5) ? BTYPE_T5 :
                (n == 6) ? BTYPE_T6 : BTYPE_T7;
        for (int k = 0; k < 8; k++)
        begin
            ctrl[7-k] = (k >= n);
            if (k < n)
            begin
                b                 = 8'($urandom);
                p[55-8*k -: 8]    = b;
                data[63-8*k -: 8] = b;
            end
            else if (k == n)
                data[63-8*k -: 8] = CGMII_TERMINATE;
            else
            begin
                p[55-7*k -: 7]    = trail;
                data[63-8*k -: 8] = (trail == PCS_IDLE) ? CGMII_IDLE : CGMII_ERROR;
            end
        end
        if (trail == PCS_IDLE || trail == PCS_ERROR)
            add_block({CTRL_SH, btype, p}, data, ctrl, RTYPE_T);
        else
            add_block({CTRL_SH, btype, p}, {8{CGMII_ERROR}}, CTRL_ALL, RTYPE_E);
    endtask

    task automatic build_stimulus();
        int guard;
        repeat (66) add_idle();  // lock comes with the 64th header
        for (int n = 0; n < 8; n++)
        begin
            add_start();
            add_data();
            add_term(n, PCS_IDLE);
            add_idle();
        end
        add_start();
        add_term(5, PCS_ERROR);
        add_ordered(1'b1);
        add_ordered(1'b0);
        add_idle();
        add_bad(CTRL_SH, 8'h33);  // unknown block type
        add_start();              // start is no way out of E
        add_idle();
        add_data();               // data right after idle
        add_term(2, PCS_IDLE);
        add_idle();
        add_start();
        add_data();
        add_term(3, 7'h2D);       // bad trailing char
        add_data();
        add_term(0, PCS_IDLE);
        add_idle();
        add_start();
        add_gap();
        add_data();
        add_gap();
        add_gap();
        add_data();
        add_term(4, PCS_IDLE);
        add_gap();
        add_idle();
        guard = 0;
        while (model_lock && guard < 80)
        begin
            add_bad(guard[0] ? 2'b11 : 2'b00, BTYPE_CTRL);
            guard++;
        end
        repeat (4) add_idle();
    endtask

    initial
    begin
        void'($urandom(32'h724f));
        i_rst_n     = 1'b0;
        i_enable    = 1'b0;
        i_rx_coded  = '0;
        model_good  = 0;
        model_win   = 0;
        model_bad   = 0;
        model_lock  = 1'b0;
        model_state = RX_INIT;
        build_stimulus();
        cycle_limit = stim_q.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge i_clock);
        #1 i_rst_n = 1'b1;
        check_value(64'(o_rx_valid), 64'(0), "o_rx_valid after reset");
        check_value(64'(o_block_lock), 64'(0), "o_block_lock after reset");
        check_value(o_rx_data, LF_DATA, "o_rx_data after reset");
        for (int i = 0; i < stim_q.size() + 2; i++)
        begin
            @(posedge i_clock);
            #1;
            if (i >= 1 && i <= stim_q.size())
                check_value(64'(o_block_lock), 64'(stim_q[i-1].exp_lock), "o_block_lock");
            if (i >= 2)
            begin
                check_value(64'(o_rx_valid), 64'(stim_q[i-2].enable), "o_rx_valid");
                if (o_rx_valid)
                begin
                    check_value(o_rx_data, stim_q[i-2].exp_data, "o_rx_data");
                    check_value(64'(o_rx_ctrl), 64'(stim_q[i-2].exp_ctrl), "o_rx_ctrl");
                end
            end
            i_enable   = (i < stim_q.size()) ? stim_q[i].enable : 1'b0;  // flush at the end
            i_rx_coded = (i < stim_q.size()) ? stim_q[i].coded : '0;
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: pcs_rx_decode.f
rtl/pcs_rx_pkg.sv
rtl/decoder_comparator.sv
rtl/block_lock.sv
rtl/rx_decode_fsm.sv
rtl/pcs_rx_decode.sv
tb/tb_pcs_rx_decode.sv

// File: Makefile
TOP := tb_pcs_rx_decode

obj_dir/V$(TOP): pcs_rx_decode.f $(shell cat pcs_rx_decode.f)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f pcs_rx_decode.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

.PHONY: run clean
